/* alu_pkg.sv */
package alu_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // operand, result and MMX register width
    localparam int xlen = 64;
    // integer datapath width before zero extension to xlen
    localparam int word_w = 32;

    ////////////////////////////////////////////////////////////
    // opcodes and operand size
    ////////////////////////////////////////////////////////////

    // codes 5 and 6 are unused
    typedef enum logic [4:0] {
        op_and       = 5'd0,
        op_add       = 5'd1,
        op_bsf       = 5'd2,
        op_pass_b    = 5'd3,
        op_pass_a    = 5'd4,
        op_cmpxchg   = 5'd7,
        op_daa       = 5'd8,
        op_not       = 5'd9,
        op_or        = 5'd10,
        op_paddw     = 5'd11,
        op_paddd     = 5'd12,
        op_packsswb  = 5'd13,
        op_packssdw  = 5'd14,
        op_punpckhbw = 5'd15,
        op_punpckhwd = 5'd16,
        op_sar       = 5'd17,
        op_sal       = 5'd18
    } alu_op_t;

    // field used for zf and sf
    typedef enum logic [1:0] {
        sz8  = 2'd0,
        sz16 = 2'd1,
        sz32 = 2'd2,
        sz64 = 2'd3
    } opsize_t;

    ////////////////////////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////////////////////////

    // decoded operation with its operands and incoming flags
    typedef struct packed {
        alu_op_t          op;
        opsize_t          size;
        logic [xlen-1:0]  op1;
        logic [xlen-1:0]  op2;
        logic [xlen-1:0]  op3;
        logic             af;
        logic             cf;
        logic             of;
    } issue_pkt_t;

    // result, cmpxchg swap indication and flags
    typedef struct packed {
        logic [xlen-1:0]  result;
        logic             swap;
        logic             cf;
        logic             pf;
        logic             af;
        logic             zf;
        logic             sf;
        logic             of;
        logic             cc_keep;
    } result_pkt_t;

endpackage

/* stage_reg.sv */
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full_q;
    payload_t data_q;

    // free slot, or the held item leaves this cycle
    assign in_ready = !full_q || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;
        end
    end

    // payload only loads on a handshake
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full_q;
    assign out_data  = data_q;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a stalled item stays put until taken
    property p_hold_when_stalled;
        @(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    a_hold_when_stalled: assert property (p_hold_when_stalled)
        else $error("stage_reg: payload changed while stalled");

endmodule

/* int_alu.sv */
`timescale 1ns/10ps

module int_alu (
    input  alu_pkg::alu_op_t         op,
    input  logic                     valid,
    input  logic [alu_pkg::xlen-1:0] op1,
    input  logic [alu_pkg::xlen-1:0] op2,
    input  logic [alu_pkg::xlen-1:0] op3,
    input  logic                     af_in,
    input  logic                     cf_in,
    input  logic                     of_in,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     swap,
    output logic                     cf,
    output logic                     af,
    output logic                     of,
    output logic                     cc_keep
);
    import alu_pkg::*;

    logic [word_w-1:0] a, b, c;
    logic [word_w-1:0] res32;
    logic [word_w:0]   add_full;
    logic [word_w:0]   cmp_full;
    logic [word_w:0]   sal_full;
    logic [word_w:0]   sar_full;
    logic [4:0]        cnt;
    logic              over;
    logic              cmp_eq;
    logic [4:0]        bsf_idx;
    logic              daa_af, daa_cf;
    logic [7:0]        daa_lo, daa_al;

    assign a = op1[word_w-1:0];
    assign b = op2[word_w-1:0];
    assign c = op3[word_w-1:0];

    // adder and cmpxchg subtract, 33 bits for the carry
    assign add_full = {1'b0, a} + {1'b0, b};
    assign cmp_full = {1'b0, c} - {1'b0, a};
    assign cmp_eq   = (a == c);

    ////////////////////////////////////////////////////////////
    // shifter
    ////////////////////////////////////////////////////////////

    assign cnt  = op2[4:0];
    assign over = |op2[7:5];
    // extra bit catches the last bit shifted out
    assign sal_full = {1'b0, a} << cnt;
    assign sar_full = $signed({a, 1'b0}) >>> cnt;

    // lowest set bit, 0 when nothing is set
    always_comb begin
        bsf_idx = '0;
        for (int i = word_w - 1; i >= 0; i--) begin
            if (a[i]) begin
                bsf_idx = 5'(i);
            end
        end
    end

    // two-step decimal adjust of al
    always_comb begin
        daa_af = (a[3:0] > 4'd9) || af_in;
        daa_lo = daa_af ? a[7:0] + 8'h06 : a[7:0];
        daa_cf = (a[7:0] > 8'h99) || cf_in;
        daa_al = daa_cf ? daa_lo + 8'h60 : daa_lo;
    end

    always_comb begin
        res32   = '0;
        swap    = 1'b0;
        cf      = 1'b0;
        af      = 1'b0;
        of      = 1'b0;
        cc_keep = 1'b0;
        case (op)
            op_and:    res32 = a & b;
            op_or:     res32 = a | b;
            op_not:    res32 = ~a;
            op_pass_a: res32 = a;
            op_pass_b: res32 = b;
            op_bsf:    res32 = {27'd0, bsf_idx};
            op_add: begin
                res32 = add_full[word_w-1:0];
                cf    = add_full[word_w];
                af    = a[4] ^ b[4] ^ add_full[4];
                of    = (a[31] == b[31]) && (add_full[31] != a[31]);
            end
            op_daa: begin
                res32 = {24'd0, daa_al};
                cf    = daa_cf;
                af    = daa_af;
            end
            op_cmpxchg: begin
                swap  = cmp_eq;
                res32 = cmp_eq ? b : a;
                cf    = cmp_full[word_w];
                af    = c[4] ^ a[4] ^ cmp_full[4];
                of    = (c[31] != a[31]) && (cmp_full[31] != c[31]);
            end
            op_sal: begin
                res32   = over ? '0 : sal_full[word_w-1:0];
                cf      = over ? a[31] : sal_full[word_w];
                of      = (cnt == 5'd1) ? (res32[31] ^ cf) : of_in;
                cc_keep = !over && (cnt == 5'd0);
            end
            op_sar: begin
                res32   = over ? {word_w{a[31]}} : sar_full[word_w:1];
                cf      = over ? a[31] : sar_full[0];
                of      = (cnt == 5'd1) ? 1'b0 : of_in;
                cc_keep = !over && (cnt == 5'd0);
            end
            default: ;
        endcase
    end

    assign result = {{(xlen - word_w){1'b0}}, res32};

    // codes 5, 6 and 19 up must never reach a live flag result
    always_comb begin
        if (valid) begin
            assert final (op inside {op_and, op_add, op_bsf, op_pass_b, op_pass_a,
                                     op_cmpxchg, op_daa, op_not, op_or, op_paddw,
                                     op_paddd, op_packsswb, op_packssdw, op_punpckhbw,
                                     op_punpckhwd, op_sar, op_sal})
                else $error("int_alu: undefined opcode %0d", op);
        end
    end

endmodule

/* simd_alu.sv */
`timescale 1ns/10ps

module simd_alu (
    input  alu_pkg::alu_op_t         op,
    input  logic [alu_pkg::xlen-1:0] op1,
    input  logic [alu_pkg::xlen-1:0] op2,
    output logic [alu_pkg::xlen-1:0] result
);
    import alu_pkg::*;

    logic [xlen-1:0] paddw_res, paddd_res;
    logic [xlen-1:0] pkwb_res, pkdw_res;
    logic [xlen-1:0] unpb_res, unpw_res;

    // signed word to signed byte with saturation
    function automatic logic [7:0] sat_w2b(input logic [15:0] w);
        logic signed [15:0] s;
        s = signed'(w);
        if (s > 16'sd127) return 8'h7f;
        if (s < -16'sd128) return 8'h80;
        return w[7:0];
    endfunction

    // signed dword to signed word with saturation
    function automatic logic [15:0] sat_d2w(input logic [31:0] d);
        logic signed [31:0] s;
        s = signed'(d);
        if (s > 32'sd32767) return 16'h7fff;
        if (s < -32'sd32768) return 16'h8000;
        return d[15:0];
    endfunction

    always_comb begin
        // lane adds wrap, carries dropped
        for (int i = 0; i < 4; i++) begin
            paddw_res[16*i +: 16] = op1[16*i +: 16] + op2[16*i +: 16];
        end
        for (int i = 0; i < 2; i++) begin
            paddd_res[32*i +: 32] = op1[32*i +: 32] + op2[32*i +: 32];
        end
        // op1 fills the low half, op2 the high half
        for (int i = 0; i < 4; i++) begin
            pkwb_res[8*i +: 8]      = sat_w2b(op1[16*i +: 16]);
            pkwb_res[32 + 8*i +: 8] = sat_w2b(op2[16*i +: 16]);
        end
        for (int i = 0; i < 2; i++) begin
            pkdw_res[16*i +: 16]      = sat_d2w(op1[32*i +: 32]);
            pkdw_res[32 + 16*i +: 16] = sat_d2w(op2[32*i +: 32]);
        end
        // interleave upper halves, op1 lane first
        for (int i = 0; i < 4; i++) begin
            unpb_res[16*i +: 8]     = op1[32 + 8*i +: 8];
            unpb_res[16*i + 8 +: 8] = op2[32 + 8*i +: 8];
        end
        for (int i = 0; i < 2; i++) begin
            unpw_res[32*i +: 16]      = op1[32 + 16*i +: 16];
            unpw_res[32*i + 16 +: 16] = op2[32 + 16*i +: 16];
        end
    end

    always_comb begin
        case (op)
            op_paddw:     result = paddw_res;
            op_paddd:     result = paddd_res;
            op_packsswb:  result = pkwb_res;
            op_packssdw:  result = pkdw_res;
            op_punpckhbw: result = unpb_res;
            op_punpckhwd: result = unpw_res;
            default:      result = '0;
        endcase
    end

endmodule

/* flag_gen.sv */
`timescale 1ns/10ps

module flag_gen (
    input  logic [alu_pkg::xlen-1:0] result,
    input  alu_pkg::opsize_t         size,
    input  logic                     unit_cf,
    input  logic                     unit_af,
    input  logic                     unit_of,
    input  logic                     zf_override_en,
    input  logic                     zf_override,
    output logic                     cf,
    output logic                     pf,
    output logic                     af,
    output logic                     zf,
    output logic                     sf,
    output logic                     of
);
    import alu_pkg::*;

    logic zf_field;

    // zero and sign from the operand-size field
    always_comb begin
        case (size)
            sz8: begin
                zf_field = ~|result[7:0];
                sf       = result[7];
            end
            sz16: begin
                zf_field = ~|result[15:0];
                sf       = result[15];
            end
            sz32: begin
                zf_field = ~|result[31:0];
                sf       = result[31];
            end
            default: begin
                zf_field = ~|result;
                sf       = result[xlen-1];
            end
        endcase
    end

    // bsf and cmpxchg decide zf themselves
    assign zf = zf_override_en ? zf_override : zf_field;
    // even parity of the low byte only
    assign pf = ~^result[7:0];

    assign cf = unit_cf;
    assign af = unit_af;
    assign of = unit_of;

endmodule

/* alu_core.sv */
`timescale 1ns/10ps

module alu_core (
    input  alu_pkg::alu_op_t         op,
    input  alu_pkg::opsize_t         size,
    input  logic                     valid,
    input  logic [alu_pkg::xlen-1:0] op1,
    input  logic [alu_pkg::xlen-1:0] op2,
    input  logic [alu_pkg::xlen-1:0] op3,
    input  logic                     af_in,
    input  logic                     cf_in,
    input  logic                     of_in,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     swap,
    output logic                     cf,
    output logic                     pf,
    output logic                     af,
    output logic                     zf,
    output logic                     sf,
    output logic                     of,
    output logic                     cc_keep
);
    import alu_pkg::*;

    logic [xlen-1:0] int_res, simd_res;
    logic            int_cf, int_af, int_of, int_keep;
    logic            is_mmx;
    logic            zf_ovr_en, zf_ovr;

    int_alu u_int (
        .op(op), .valid(valid), .op1(op1), .op2(op2), .op3(op3),
        .af_in(af_in), .cf_in(cf_in), .of_in(of_in),
        .result(int_res), .swap(swap),
        .cf(int_cf), .af(int_af), .of(int_of), .cc_keep(int_keep)
    );

    simd_alu u_simd (.op(op), .op1(op1), .op2(op2), .result(simd_res));

    assign is_mmx = op inside {op_paddw, op_paddd, op_packsswb, op_packssdw,
                               op_punpckhbw, op_punpckhwd};
    assign result = is_mmx ? simd_res : int_res;
    // mmx ops leave eflags alone
    assign cc_keep = int_keep || is_mmx;

    // bsf: source zero; cmpxchg: operands matched
    assign zf_ovr_en = (op == op_bsf) || (op == op_cmpxchg);
    assign zf_ovr    = (op == op_bsf) ? (op1[word_w-1:0] == '0) : swap;

    flag_gen u_flags (
        .result(result), .size(size),
        .unit_cf(int_cf), .unit_af(int_af), .unit_of(int_of),
        .zf_override_en(zf_ovr_en), .zf_override(zf_ovr),
        .cf(cf), .pf(pf), .af(af), .zf(zf), .sf(sf), .of(of)
    );

endmodule

/* exe_stage.sv */
`timescale 1ns/10ps

module exe_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  alu_pkg::alu_op_t         op,
    input  alu_pkg::opsize_t         size,
    input  logic [alu_pkg::xlen-1:0] op1,
    input  logic [alu_pkg::xlen-1:0] op2,
    input  logic [alu_pkg::xlen-1:0] op3,
    input  logic                     af_in,
    input  logic                     cf_in,
    input  logic                     of_in,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     swap,
    output logic                     cf,
    output logic                     pf,
    output logic                     af,
    output logic                     zf,
    output logic                     sf,
    output logic                     of,
    output logic                     cc_keep
);
    import alu_pkg::*;

    issue_pkt_t  iss_in, iss_q;
    result_pkt_t res_d, res_q;
    logic        iss_valid, res_ready;

    assign iss_in = '{op: op, size: size, op1: op1, op2: op2, op3: op3,
                      af: af_in, cf: cf_in, of: of_in};

    ////////////////////////////////////////////////////////////
    // operand register, alu, result register
    ////////////////////////////////////////////////////////////

    stage_reg #(.payload_t(issue_pkt_t)) u_in_reg (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(iss_in),
        .out_valid(iss_valid), .out_ready(res_ready), .out_data(iss_q)
    );

    alu_core u_core (
        .op(iss_q.op), .size(iss_q.size), .valid(iss_valid),
        .op1(iss_q.op1), .op2(iss_q.op2), .op3(iss_q.op3),
        .af_in(iss_q.af), .cf_in(iss_q.cf), .of_in(iss_q.of),
        .result(res_d.result), .swap(res_d.swap),
        .cf(res_d.cf), .pf(res_d.pf), .af(res_d.af), .zf(res_d.zf),
        .sf(res_d.sf), .of(res_d.of), .cc_keep(res_d.cc_keep)
    );

    stage_reg #(.payload_t(result_pkt_t)) u_out_reg (
        .clk(clk), .rst_n(rst_n),
        .in_valid(iss_valid), .in_ready(res_ready), .in_data(res_d),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(res_q)
    );

    assign result  = res_q.result;
    assign swap    = res_q.swap;
    assign cf      = res_q.cf;
    assign pf      = res_q.pf;
    assign af      = res_q.af;
    assign zf      = res_q.zf;
    assign sf      = res_q.sf;
    assign of      = res_q.of;
    assign cc_keep = res_q.cc_keep;

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int period_ns  = 100,
    parameter int rst_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a rising edge after the reset window
    initial begin
        rst_n <= 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb_exe_stage.sv */
`timescale 1ns/10ps

module tb_exe_stage;
    import alu_pkg::*;

    localparam int n_items        = 2000;
    localparam int burst_n        = 8;
    localparam int rst_cycles     = 8;
    localparam int timeout_cycles = n_items * 4 + rst_cycles;

    typedef struct {
        result_pkt_t pkt;
        int          cycle;
        bit          timed;
        bit          mmx;
    } sb_entry_t;

    logic            clk, rst_n;
    logic            in_valid, in_ready, out_valid, out_ready;
    alu_op_t         op;
    opsize_t         size;
    logic [xlen-1:0] op1, op2, op3, result;
    logic            af_in, cf_in, of_in;
    logic            swap, cf, pf, af, zf, sf, of, cc_keep;

    sb_entry_t   sb_q[$];
    sb_entry_t   ent;
    sb_entry_t   got;
    int          cycles = 0;
    int          issued = 0;
    int          received = 0;
    int          phase = 0;

    alu_op_t op_list[17] = '{op_and, op_or, op_not, op_add, op_pass_a, op_pass_b, op_bsf,
                             op_daa, op_cmpxchg, op_sal, op_sar, op_paddw, op_paddd,
                             op_packsswb, op_packssdw, op_punpckhbw, op_punpckhwd};

    tb_clk_gen #(.period_ns(100), .rst_cycles(rst_cycles)) u_clk (.clk(clk), .rst_n(rst_n));

    exe_stage dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .size(size), .op1(op1), .op2(op2), .op3(op3),
        .af_in(af_in), .cf_in(cf_in), .of_in(of_in),
        .out_valid(out_valid), .out_ready(out_ready), .result(result), .swap(swap),
        .cf(cf), .pf(pf), .af(af), .zf(zf), .sf(sf), .of(of), .cc_keep(cc_keep)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got_v,
                               input logic [63:0] exp_v);
        if (got_v !== exp_v) begin
            fail_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got_v, exp_v));
        end
    endtask

    function automatic bit is_mmx_op(input alu_op_t opc);
        return opc inside {op_paddw, op_paddd, op_packsswb, op_packssdw,
                           op_punpckhbw, op_punpckhwd};
    endfunction

    function automatic int clamp_int(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic result_pkt_t model_result(input alu_op_t opc, input opsize_t sz,
                                                 input logic [63:0] x1, input logic [63:0] x2,
                                                 input logic [63:0] x3, input logic af_i,
                                                 input logic cf_i, input logic of_i);
        result_pkt_t e;
        logic [31:0] a, b, c, r;
        logic [63:0] res;
        logic [7:0]  al;
        logic        zf_set, zf_val, over;
        longint      s;
        int          cnt, i, v;
        e = '0;
        a = x1[31:0];
        b = x2[31:0];
        c = x3[31:0];
        r = '0;
        res = '0;
        zf_set = 1'b0;
        zf_val = 1'b0;
        cnt = x2[4:0];
        over = |x2[7:5];
        case (opc)
            op_and:    r = a & b;
            op_or:     r = a | b;
            op_not:    r = ~a;
            op_pass_a: r = a;
            op_pass_b: r = b;
            op_add: begin
                s = longint'(a) + longint'(b);
                r = s[31:0];
                e.cf = s[32];
                e.af = (a[3:0] + b[3:0]) > 15;
                // overflow when the true signed sum does not fit
                s = longint'($signed(a)) + longint'($signed(b));
                e.of = s != longint'($signed(r));
            end
            op_bsf: begin
                zf_set = 1'b1;
                zf_val = (a == 0);
                i = 0;
                while (i < 32 && !a[i]) i++;
                r = (i < 32) ? 32'(i) : 32'd0;
            end
            op_daa: begin
                al = a[7:0];
                e.af = (al[3:0] > 9) || af_i;
                if (e.af) al = al + 8'h06;
                e.cf = (a[7:0] > 8'h99) || cf_i;
                if (e.cf) al = al + 8'h60;
                r = {24'd0, al};
            end
            op_cmpxchg: begin
                zf_set = 1'b1;
                zf_val = (a == c);
                e.swap = (a == c);
                r = e.swap ? b : a;
                // flags of op3 minus op1
                e.cf = c < a;
                e.af = c[3:0] < a[3:0];
                s = longint'($signed(c)) - longint'($signed(a));
                e.of = s != longint'($signed(c - a));
            end
            op_sal: begin
                if (over) begin
                    r = '0;
                    e.cf = a[31];
                end else begin
                    r = a << cnt;
                    if (cnt != 0) e.cf = a[32 - cnt];
                end
                e.of = (cnt == 1) ? (r[31] ^ e.cf) : of_i;
                e.cc_keep = !over && (cnt == 0);
            end
            op_sar: begin
                if (over) begin
                    r = {32{a[31]}};
                    e.cf = a[31];
                end else begin
                    r = $signed(a) >>> cnt;
                    if (cnt != 0) e.cf = a[cnt - 1];
                end
                e.of = (cnt == 1) ? 1'b0 : of_i;
                e.cc_keep = !over && (cnt == 0);
            end
            op_paddw: begin
                for (i = 0; i < 4; i++) res[16*i +: 16] = x1[16*i +: 16] + x2[16*i +: 16];
            end
            op_paddd: begin
                for (i = 0; i < 2; i++) res[32*i +: 32] = x1[32*i +: 32] + x2[32*i +: 32];
            end
            op_packsswb: begin
                for (i = 0; i < 4; i++) begin
                    v = clamp_int($signed(x1[16*i +: 16]), -128, 127);
                    res[8*i +: 8] = v[7:0];
                    v = clamp_int($signed(x2[16*i +: 16]), -128, 127);
                    res[32 + 8*i +: 8] = v[7:0];
                end
            end
            op_packssdw: begin
                for (i = 0; i < 2; i++) begin
                    v = clamp_int($signed(x1[32*i +: 32]), -32768, 32767);
                    res[16*i +: 16] = v[15:0];
                    v = clamp_int($signed(x2[32*i +: 32]), -32768, 32767);
                    res[32 + 16*i +: 16] = v[15:0];
                end
            end
            op_punpckhbw: begin
                for (i = 0; i < 4; i++) begin
                    res[16*i +: 8]     = x1[32 + 8*i +: 8];
                    res[16*i + 8 +: 8] = x2[32 + 8*i +: 8];
                end
            end
            op_punpckhwd: begin
                for (i = 0; i < 2; i++) begin
                    res[32*i +: 16]      = x1[32 + 16*i +: 16];
                    res[32*i + 16 +: 16] = x2[32 + 16*i +: 16];
                end
            end
            default: ;
        endcase
        if (is_mmx_op(opc)) begin
            e.result = res;
            e.cc_keep = 1'b1;
        end else begin
            e.result = {32'd0, r};
        end
        case (sz)
            sz8:     {e.zf, e.sf} = {e.result[7:0] == 0, e.result[7]};
            sz16:    {e.zf, e.sf} = {e.result[15:0] == 0, e.result[15]};
            sz32:    {e.zf, e.sf} = {e.result[31:0] == 0, e.result[31]};
            default: {e.zf, e.sf} = {e.result == 0, e.result[63]};
        endcase
        if (zf_set) e.zf = zf_val;
        e.pf = ~^e.result[7:0];
        return e;
    endfunction

    task automatic compare_result(input sb_entry_t e);
        check_value("result", result, e.pkt.result);
        check_value("swap", swap, e.pkt.swap);
        check_value("cc_keep", cc_keep, e.pkt.cc_keep);
        // mmx flags are don't-care
        if (!e.mmx) begin
            check_value("cf", cf, e.pkt.cf);
            check_value("pf", pf, e.pkt.pf);
            check_value("af", af, e.pkt.af);
            check_value("zf", zf, e.pkt.zf);
            check_value("sf", sf, e.pkt.sf);
            check_value("of", of, e.pkt.of);
        end
        if (e.timed) check_value("latency", cycles - e.cycle, 2);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic present_item();
        logic [63:0] v1, v2, v3;
        v1 = {$urandom, $urandom};
        v2 = {$urandom, $urandom};
        v3 = {$urandom, $urandom};
        // small lanes so the packs do not always saturate
        case ($urandom_range(0, 3))
            0: v1 = v1 & 64'h00ff_00ff_00ff_00ff;
            1: begin
                v1 = {{16{v1[47]}}, v1[47:32], {16{v1[15]}}, v1[15:0]};
                v2 = {{16{v2[47]}}, v2[47:32], {16{v2[15]}}, v2[15:0]};
            end
            default: ;
        endcase
        if ($urandom_range(0, 15) == 0) v1[31:0] = '0;
        if ($urandom_range(0, 3) == 0) v3[31:0] = v1[31:0];
        if ($urandom_range(0, 3) != 0) v2[7:5] = 3'b000;
        case ($urandom_range(0, 7))
            0: v2[4:0] = 5'd0;
            1: v2[4:0] = 5'd1;
            default: ;
        endcase
        in_valid <= 1'b1;
        op       <= op_list[$urandom_range(0, 16)];
        size     <= opsize_t'($urandom_range(0, 3));
        op1      <= v1;
        op2      <= v2;
        op3      <= v3;
        af_in    <= $urandom_range(0, 1);
        cf_in    <= $urandom_range(0, 1);
        of_in    <= $urandom_range(0, 1);
    endtask

    // new item only once the previous one was taken
    task automatic drive_step();
        if (!in_valid || in_ready) begin
            if ((phase == 1 && issued < burst_n) ||
                (phase == 3 && issued < n_items && $urandom_range(0, 3) != 0)) begin
                present_item();
                issued++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        out_ready <= (phase == 3) ? ($urandom_range(0, 3) != 0) : 1'b1;
    endtask

    initial begin
        void'($urandom(32'h68ad5513));
        in_valid  = 1'b0;
        out_ready = 1'b0;
        op        = op_and;
        size      = sz8;
        op1       = '0;
        op2       = '0;
        op3       = '0;
        af_in     = 1'b0;
        cf_in     = 1'b0;
        of_in     = 1'b0;
        @(posedge rst_n);
        // directed burst followed by random traffic
        phase <= 1;
        while (received < n_items) begin
            @(posedge clk);
            if (phase == 1 && received == burst_n) phase <= 3;
            drive_step();
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (sb_q.size() != 0) begin
            fail_run($sformatf("%0d items were lost in the pipeline", sb_q.size()));
        end else if (out_valid) begin
            fail_run("an extra result appeared after all items were received");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // scoreboard and timeout
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            check_value("out_valid", out_valid, 1'b0);
        end else begin
            if (in_valid && in_ready) begin
                ent.pkt   = model_result(op, size, op1, op2, op3, af_in, cf_in, of_in);
                ent.cycle = cycles;
                ent.timed = (phase == 1);
                ent.mmx   = is_mmx_op(op);
                sb_q.push_back(ent);
            end
            if (out_valid && out_ready) begin
                if (sb_q.size() == 0) begin
                    fail_run("a result came out with no input item waiting for it");
                end else begin
                    got = sb_q.pop_front();
                    compare_result(got);
                    received <= received + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            fail_run($sformatf("run hung: %0d of %0d items received", received, n_items));
        end
    end

endmodule

/* files.f */
alu_pkg.sv
stage_reg.sv
int_alu.sv
simd_alu.sv
flag_gen.sv
alu_core.sv
exe_stage.sv
tb_clk_gen.sv
tb_exe_stage.sv

/* Bender.yml */
package:
  name: exe_stage

sources:
  - alu_pkg.sv
  - stage_reg.sv
  - int_alu.sv
  - simd_alu.sv
  - flag_gen.sv
  - alu_core.sv
  - exe_stage.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_exe_stage.sv
